//--- main_reg_block.f
+incdir+verilog
verilog/main_reg_pkg.sv
verilog/reg_access_if.sv
verilog/byte_field_reg.sv
verilog/capture_ctrl_regs.sv
verilog/fifo_read_port.sv
verilog/reg_bus_port.sv
verilog/main_reg_block.sv
verification/tb_clock_gen.sv
verification/main_reg_block_chk.sv
verification/tb_main_reg_block.sv

//--- Makefile
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -Wall
TOP       ?= tb_main_reg_block
FILELIST  ?= main_reg_block.f
OBJDIR    ?= obj_dir

.PHONY: all compile run clean

all: run

compile: $(OBJDIR)/V$(TOP)

$(OBJDIR)/V$(TOP): $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJDIR)

run: compile
	./$(OBJDIR)/V$(TOP)

clean:
	rm -rf $(OBJDIR)

//--- verification/main_reg_cases.txt
// op addr bytecnt data expect
// op 0 write, 1 read, 2 frame (data=status, expect 1 data/0 marker), 3 push,
// 4 port check (addr=port), 5 flushing, 6 capture enable, 7 pulse count, ff end
1 05 00 00 00
1 05 01 00 00
1 05 02 00 00
1 08 00 00 ff
1 08 01 00 ff
4 00 00 00 00
4 07 00 00 00
0 05 00 12 00
0 05 01 34 00
0 05 02 56 00
1 05 00 00 12
1 05 01 00 34
1 05 02 00 56
4 02 00 00 12
4 02 02 00 56
0 08 00 cd 00
0 08 01 ab 00
1 08 00 00 cd
1 08 01 00 ab
4 03 01 00 ab
1 00 00 00 4d
1 00 01 00 3c
1 00 02 00 2b
1 00 03 00 1a
0 45 00 ee 00
1 05 00 00 12
1 45 00 00 00
1 40 00 00 00
7 00 00 00 00
0 03 00 01 00
7 00 00 00 01
4 00 00 00 01
4 01 00 00 01
1 03 00 00 01
6 00 00 00 00
4 01 00 00 00
4 00 00 00 00
5 00 00 01 00
0 03 00 01 00
7 00 00 00 02
4 00 00 00 00
4 01 00 00 01
5 00 00 00 00
4 00 00 00 01
6 00 00 00 00
0 03 00 02 00
7 01 00 00 01
0 09 00 01 00
7 02 00 00 01
4 07 00 00 00
0 04 00 01 00
1 04 00 00 01
0 06 00 01 00
1 06 00 00 01
0 07 00 01 00
1 07 00 00 01
4 04 00 00 01
4 05 00 00 01
4 06 00 00 01
1 01 00 00 00
3 00 00 00 00
2 02 00 15 01
7 03 00 00 01
2 02 00 2a 00
7 03 00 00 01
3 00 00 00 00
2 02 00 07 01
7 03 00 00 02
1 01 00 00 07
ff ff ff ff ff

//--- verification/tb_main_reg_block.sv
// testbench top with cases file driver, FIFO model, result checks and timeout
`timescale 1ns/10ps
`default_nettype none

`include "main_reg_macros.svh"

module tb_main_reg_block
   import main_reg_pkg::*;
();

   localparam int MAX_CASES     = 96;
   localparam int CYCLES_PER_OP = 40;

   logic           cwusb_clk, fpga_reset;
   logic [7:0]     reg_address;
   bytecnt_t       reg_bytecnt;
   byte_t          write_data, read_data;
   logic           reg_read, reg_write, reg_addrvalid;
   logic [31:0]    buildtime;
   fifo_word_t     fifo_data;
   fifo_status_t   fifo_status;
   logic           fifo_empty, fifo_read;
   logic           flushing, capture_enable_pulse;
   logic           arm, reg_arm, arm_pulse, capture_now, capture_off;
   capture_len_t   capture_len;
   logic           count_writes, timestamps_disable, clear_errors;
   max_timestamp_t max_timestamp;

   byte_t      cases [0:5*MAX_CASES-1];
   fifo_word_t fifo_q[$];
   int         n_cases, cycle_cnt, popped;
   int         pulse_cnt [0:3];   // arm_pulse, capture_now, clear_errors, fifo_read
   string      pulse_sig [0:3] = '{"arm_pulse", "capture_now", "clear_errors", "fifo_read"};
   string      port_sig [0:7]  = '{"arm", "reg_arm", "capture_len", "max_timestamp",
                                   "capture_off", "count_writes", "timestamps_disable",
                                   "clear_errors"};

   tb_clock_gen i_tb_clock_gen (.cwusb_clk(cwusb_clk), .fpga_reset(fpga_reset));

   main_reg_block i_main_reg_block (.*);

   bind main_reg_block main_reg_block_chk i_main_reg_block_chk (
      .cwusb_clk(cwusb_clk), .fpga_reset(fpga_reset), .arm_pulse(arm_pulse),
      .capture_now(capture_now), .clear_errors(clear_errors),
      .fifo_read(fifo_read), .fifo_empty(fifo_empty)
   );

   task automatic report_fail(input string msg);
      $display("%s", msg);
      $display("TEST RESULT: FAIL");
      $fatal(1);
   endtask

   task automatic check_byte(input string name, input byte_t got, input byte_t exp);
      assert (got === exp)
      else report_fail($sformatf("Fail %s: got %h, expected %h", name, got, exp));
   endtask

   ////////////////////////////////////////////////////////////
   // pulse counters and cycle limit

   always @(posedge cwusb_clk) begin
      if (!fpga_reset) begin
         if (arm_pulse)    pulse_cnt[0] <= pulse_cnt[0] + 1;
         if (capture_now)  pulse_cnt[1] <= pulse_cnt[1] + 1;
         if (clear_errors) pulse_cnt[2] <= pulse_cnt[2] + 1;
         if (fifo_read)    pulse_cnt[3] <= pulse_cnt[3] + 1;
      end
      cycle_cnt <= cycle_cnt + 1;
      if (n_cases > 0 && cycle_cnt > n_cases * CYCLES_PER_OP)
         report_fail("timeout: the cases did not finish within the cycle limit");
   end

   // one falling edge, then update the FIFO model outputs
   task automatic tick();
      @(negedge cwusb_clk);
      while (popped < pulse_cnt[3]) begin
         if (fifo_q.size() != 0) void'(fifo_q.pop_front());
         popped++;
      end
      fifo_empty = (fifo_q.size() == 0);
      fifo_data  = fifo_empty ? '0 : fifo_q[0];
   endtask

   function automatic byte_t port_value(input byte_t idx, input byte_t bcnt);
      case (idx)
         8'd0:    return {7'b0, arm};
         8'd1:    return {7'b0, reg_arm};
         8'd2:    return capture_len[bcnt[1:0]*8 +: 8];
         8'd3:    return max_timestamp[bcnt[0]*8 +: 8];
         8'd4:    return {7'b0, capture_off};
         8'd5:    return {7'b0, count_writes};
         8'd6:    return {7'b0, timestamps_disable};
         default: return {7'b0, clear_errors};
      endcase
   endfunction

   task automatic bus_access(input logic wr, input byte_t addr, input byte_t bcnt,
                             input byte_t data);
      reg_address   = addr;
      reg_bytecnt   = bytecnt_t'(bcnt);
      write_data    = data;
      reg_write     = wr;
      reg_read      = !wr;
      reg_addrvalid = 1'b1;
   endtask

   task automatic bus_idle();
      reg_write     = 1'b0;
      reg_read      = 1'b0;
      reg_addrvalid = 1'b0;
   endtask

   // 4-byte frame read of the FIFO register with bytes back to back
   task automatic frame_read(input byte_t status, input logic expect_data);
      fifo_word_t word;
      byte_t      exp [0:3];
      int         reads_before;
      word = '0;
      word[1:0] = 2'(`FIFO_CMD_STRM);   // marker word
      if (expect_data) begin
         if (fifo_q.size() == 0) report_fail("frame read expects data but the FIFO is empty");
         word = fifo_q[0];
      end
      fifo_status = fifo_status_t'(status);
      exp[0] = 8'h00;
      exp[1] = word[7:0];
      exp[2] = word[15:8];
      exp[3] = {status[5:0], word[17:16]};
      reads_before = pulse_cnt[3];
      for (int b = 0; b < 4; b++) begin
         bus_access(1'b0, 8'(`REG_FIFO_RD), 8'(b), 8'h00);
         tick();
         check_byte($sformatf("read_data frame byte %0d", b), read_data, exp[b]);
      end
      bus_idle();
      check_byte("fifo_read count", 8'(pulse_cnt[3] - reads_before), 8'(expect_data));
   endtask

   ////////////////////////////////////////////////////////////
   // main sequence

   initial begin
      byte_t op, addr, bcnt, data, expv;
      void'($urandom(79));
      for (int i = 0; i < 5*MAX_CASES; i++) cases[i] = 8'hff;
      $readmemh("verification/main_reg_cases.txt", cases);
      n_cases = 0;
      while (n_cases < MAX_CASES && cases[5*n_cases] != 8'hff) n_cases++;
      for (int i = 0; i < 4; i++) pulse_cnt[i] = 0;
      cycle_cnt = 0;
      popped = 0;
      buildtime = 32'h1a2b3c4d;
      fifo_status = '0;
      fifo_data = '0;
      fifo_empty = 1'b1;
      flushing = 1'b0;
      capture_enable_pulse = 1'b0;
      reg_address = '0;
      reg_bytecnt = '0;
      write_data = '0;
      bus_idle();
      if (n_cases == 0) report_fail("no cases read from the cases file");
      while (fpga_reset) tick();

      for (int c = 0; c < n_cases; c++) begin
         op   = cases[5*c];
         addr = cases[5*c+1];
         bcnt = cases[5*c+2];
         data = cases[5*c+3];
         expv = cases[5*c+4];
         case (op)
            8'h0: begin
               bus_access(1'b1, addr, bcnt, data);
               tick();
               bus_idle();
            end
            8'h1: begin
               bus_access(1'b0, addr, bcnt, 8'h00);
               tick();
               check_byte($sformatf("read_data addr %h byte %0d", addr, bcnt), read_data, expv);
               bus_idle();
            end
            8'h2: frame_read(data, expv[0]);
            8'h3: begin
               fifo_q.push_back(fifo_word_t'($urandom));
               fifo_empty = 1'b0;
               fifo_data  = fifo_q[0];
            end
            8'h4: check_byte($sformatf("%s byte %0d", port_sig[addr[2:0]], bcnt),
                             port_value(addr, bcnt), expv);
            8'h5: flushing = data[0];
            8'h6: begin
               capture_enable_pulse = 1'b1;
               tick();
               capture_enable_pulse = 1'b0;
            end
            8'h7: check_byte($sformatf("%s count", pulse_sig[addr[1:0]]),
                             8'(pulse_cnt[addr[1:0]]), expv);
            default: report_fail($sformatf("unknown operation %h in the cases file", op));
         endcase
         repeat (1 + $urandom % 3) tick();   // idle gap of at least one cycle
      end

      $display("TEST RESULT: PASS");
      $finish;
   end

endmodule

`default_nettype wire

//--- verification/main_reg_block_chk.sv
// concurrent assertions on pulse outputs and FIFO reads
`timescale 1ns/10ps
`default_nettype none

module main_reg_block_chk (
   input wire cwusb_clk,
   input wire fpga_reset,
   input wire arm_pulse,
   input wire capture_now,
   input wire clear_errors,
   input wire fifo_read,
   input wire fifo_empty
);

   ////////////////////////////////////////////////////////////
   // single-cycle pulses

   a_arm_pulse_single : assert property (@(posedge cwusb_clk) disable iff (fpga_reset)
      arm_pulse |=> !arm_pulse)
      else $error("arm_pulse high for two cycles");

   a_capture_now_single : assert property (@(posedge cwusb_clk) disable iff (fpga_reset)
      capture_now |=> !capture_now)
      else $error("capture_now high for two cycles");

   a_clear_errors_single : assert property (@(posedge cwusb_clk) disable iff (fpga_reset)
      clear_errors |=> !clear_errors)
      else $error("clear_errors high for two cycles");

   // empty flag is registered inside the DUT
   a_no_read_when_empty : assert property (@(posedge cwusb_clk) disable iff (fpga_reset)
      fifo_read |-> !$past(fifo_empty))
      else $error("fifo_read while the FIFO was empty");

endmodule

`default_nettype wire

//--- verification/tb_clock_gen.sv
// testbench clock and reset generator
`timescale 1ns/10ps
`default_nettype none

module tb_clock_gen (
   output logic cwusb_clk,
   output logic fpga_reset
);

   initial begin
      cwusb_clk = 1'b0;
      forever #50 cwusb_clk = ~cwusb_clk;   // 100 ns period
   end

   initial begin
      fpga_reset = 1'b1;
      repeat (4) @(posedge cwusb_clk);
      @(negedge cwusb_clk);
      fpga_reset = 1'b0;
   end

endmodule

`default_nettype wire

//--- verilog/main_reg_block.sv
// main register block top level: bus port, capture control registers and FIFO read port
`timescale 1ns/10ps
`default_nettype none

module main_reg_block
   import main_reg_pkg::*;
(
   input  wire            cwusb_clk,
   input  wire            fpga_reset,

   // USB register bus
   input  wire [7:0]      reg_address,
   input  wire bytecnt_t  reg_bytecnt,
   input  wire byte_t     write_data,
   input  wire            reg_read,
   input  wire            reg_write,
   input  wire            reg_addrvalid,
   output byte_t          read_data,

   input  wire [31:0]     buildtime,

   // sample FIFO
   input  wire fifo_word_t   fifo_data,
   input  wire fifo_status_t fifo_status,
   input  wire            fifo_empty,
   output logic           fifo_read,

   // capture front end
   input  wire            flushing,
   input  wire            capture_enable_pulse,
   output logic           arm,
   output logic           reg_arm,
   output logic           arm_pulse,
   output logic           capture_now,
   output logic           capture_off,
   output capture_len_t   capture_len,
   output logic           count_writes,
   output logic           timestamps_disable,
   output max_timestamp_t max_timestamp,
   output logic           clear_errors
);

   byte_t ctrl_rdata;   // read byte from the control registers
   byte_t fifo_rdata;   // read byte from the FIFO port

   reg_access_if acc ();

   reg_bus_port i_reg_bus_port (
      .cwusb_clk     (cwusb_clk),
      .fpga_reset    (fpga_reset),
      .reg_address   (reg_address),
      .reg_bytecnt   (reg_bytecnt),
      .write_data    (write_data),
      .reg_read      (reg_read),
      .reg_write     (reg_write),
      .reg_addrvalid (reg_addrvalid),
      .buildtime     (buildtime),
      .ctrl_rdata    (ctrl_rdata),
      .fifo_rdata    (fifo_rdata),
      .read_data     (read_data),
      .acc           (acc.port)
   );

   capture_ctrl_regs i_capture_ctrl_regs (
      .cwusb_clk            (cwusb_clk),
      .fpga_reset           (fpga_reset),
      .flushing             (flushing),
      .capture_enable_pulse (capture_enable_pulse),
      .acc                  (acc.regs),
      .rdata                (ctrl_rdata),
      .arm                  (arm),
      .reg_arm              (reg_arm),
      .arm_pulse            (arm_pulse),
      .capture_now          (capture_now),
      .capture_off          (capture_off),
      .count_writes         (count_writes),
      .timestamps_disable   (timestamps_disable),
      .clear_errors         (clear_errors),
      .capture_len          (capture_len),
      .max_timestamp        (max_timestamp)
   );

   fifo_read_port i_fifo_read_port (
      .cwusb_clk   (cwusb_clk),
      .fpga_reset  (fpga_reset),
      .fifo_data   (fifo_data),
      .fifo_status (fifo_status),
      .fifo_empty  (fifo_empty),
      .acc         (acc.regs),
      .fifo_read   (fifo_read),
      .rdata       (fifo_rdata)
   );

endmodule

`default_nettype wire

//--- verilog/reg_bus_port.sv
// select decode, access strobes, build-time read, read merge and output register
`timescale 1ns/10ps
`default_nettype none

`include "main_reg_macros.svh"

module reg_bus_port
   import main_reg_pkg::*;
(
   input  wire            cwusb_clk,
   input  wire            fpga_reset,
   input  wire [7:0]      reg_address,
   input  wire bytecnt_t  reg_bytecnt,
   input  wire byte_t     write_data,
   input  wire            reg_read,
   input  wire            reg_write,
   input  wire            reg_addrvalid,
   input  wire [31:0]     buildtime,
   input  wire byte_t     ctrl_rdata,
   input  wire byte_t     fifo_rdata,
   output byte_t          read_data,
   reg_access_if.port     acc
);

   logic  selected;
   logic  rd_q;           // selected read, one cycle late
   byte_t bt_byte;
   byte_t rdata_merge;

   ////////////////////////////////////////////////////////////
   // select decode and access strobes

   assign selected = reg_addrvalid && (reg_address[7:6] == `MAIN_REG_SELECT);

   assign acc.addr    = reg_address[5:0];
   assign acc.bytecnt = reg_bytecnt;
   assign acc.wdata   = write_data;
   assign acc.wr      = selected && reg_write;
   assign acc.rd      = selected && reg_read;

   // high only while a new read starts
   assign acc.rd_first = acc.rd && !rd_q;

   always_ff @(posedge cwusb_clk) begin
      if (fpga_reset) begin
         rd_q <= 1'b0;
      end else begin
         rd_q <= acc.rd;
      end
   end

   ////////////////////////////////////////////////////////////
   // build time bytes served here

   always_comb begin
      bt_byte = '0;
      if (acc.rd && (acc.addr == `REG_BUILDTIME) && (reg_bytecnt < bytecnt_t'(4)))
         bt_byte = buildtime[reg_bytecnt[1:0]*8 +: 8];
   end

   ////////////////////////////////////////////////////////////
   // read merge and output register

   // each source returns zero outside its own addresses
   assign rdata_merge = bt_byte | ctrl_rdata | fifo_rdata;

   always_ff @(posedge cwusb_clk) begin
      read_data <= rdata_merge;   // data one cycle after the request
   end

endmodule

`default_nettype wire

//--- verilog/fifo_read_port.sv
// FIFO read strobe, word latch, streaming empty marker, frame byte select and status read
`timescale 1ns/10ps
`default_nettype none

`include "main_reg_macros.svh"

module fifo_read_port
   import main_reg_pkg::*;
(
   input  wire               cwusb_clk,
   input  wire               fpga_reset,
   input  wire fifo_word_t   fifo_data,
   input  wire fifo_status_t fifo_status,
   input  wire               fifo_empty,
   reg_access_if.regs        acc,
   output logic              fifo_read,
   output byte_t             rdata
);

   logic       fifo_empty_r;
   logic       marker_q;       // last frame start found the FIFO empty
   logic       byte3_done;     // byte 3 read since the last frame start
   logic       fifo_addr;
   logic       frame_start;
   fifo_word_t word_q;
   fifo_word_t marker_word;
   fifo_word_t frame_word;

   ////////////////////////////////////////////////////////////
   // frame start and FIFO read

   assign fifo_addr   = acc.rd && (acc.addr == `REG_FIFO_RD);
   assign frame_start = fifo_addr && acc.rd_first && (acc.bytecnt[1:0] == 2'd0);

   // no read while a pending marker frame is unfinished
   assign fifo_read = frame_start && !fifo_empty_r && (!marker_q || byte3_done);

   always_ff @(posedge cwusb_clk) begin
      if (fpga_reset) begin
         fifo_empty_r <= 1'b1;   // treat as empty until sampled
         marker_q     <= 1'b0;
         byte3_done   <= 1'b0;
      end else begin
         fifo_empty_r <= fifo_empty;
         if (frame_start) begin
            byte3_done <= 1'b0;
            if (fifo_empty_r)
               marker_q <= 1'b1;
            else if (byte3_done)
               marker_q <= 1'b0;   // data again after a complete marker frame
         end else if (fifo_addr && (acc.bytecnt[1:0] == 2'd3)) begin
            byte3_done <= 1'b1;
         end
      end
   end

   always_ff @(posedge cwusb_clk) begin
      if (fifo_read)
         word_q <= fifo_data;
   end

   ////////////////////////////////////////////////////////////
   // frame byte select

   always_comb begin
      marker_word = '0;
      marker_word[`FIFO_CMD_START +: `FIFO_CMD_LEN]   = `FIFO_CMD_STRM;
      marker_word[`FIFO_DATA_START +: `FIFO_DATA_LEN] = `FIFO_STRM_EMPTY;
   end

   assign frame_word = marker_q ? marker_word : word_q;

   always_comb begin
      rdata = '0;
      if (fifo_addr) begin
         case (acc.bytecnt[1:0])
            2'd1:    rdata = frame_word[7:0];
            2'd2:    rdata = frame_word[15:8];
            2'd3:    rdata = {fifo_status, frame_word[17:16]};
            default: rdata = '0;   // byte 0 is always zero
         endcase
      end else if (acc.rd && (acc.addr == `REG_FIFO_STAT)) begin
         rdata = {2'b00, fifo_status};
      end
   end

endmodule

`default_nettype wire

//--- verilog/capture_ctrl_regs.sv
// capture control bits, ARM and capture-now pulses, clear-errors pulse and read-back
`timescale 1ns/10ps
`default_nettype none

`include "main_reg_macros.svh"

module capture_ctrl_regs
   import main_reg_pkg::*;
(
   input  wire            cwusb_clk,
   input  wire            fpga_reset,
   input  wire            flushing,
   input  wire            capture_enable_pulse,
   reg_access_if.regs     acc,
   output byte_t          rdata,
   output logic           arm,
   output logic           reg_arm,
   output logic           arm_pulse,
   output logic           capture_now,
   output logic           capture_off,
   output logic           count_writes,
   output logic           timestamps_disable,
   output logic           clear_errors,
   output capture_len_t   capture_len,
   output max_timestamp_t max_timestamp
);

   logic  reg_arm_r;
   logic  capture_now_q;
   logic  capture_now_r;
   logic  arm_wr;
   logic  clr_wr;
   byte_t len_rd_byte;
   byte_t mts_rd_byte;

   assign arm_wr = acc.wr && (acc.addr == `REG_ARM);
   assign clr_wr = acc.wr && (acc.addr == `REG_CLEAR_ERRORS);

   ////////////////////////////////////////////////////////////
   // control bits and pulses

   always_ff @(posedge cwusb_clk) begin
      if (fpga_reset) begin
         reg_arm            <= 1'b0;
         reg_arm_r          <= 1'b0;
         capture_now_q      <= 1'b0;
         capture_now_r      <= 1'b0;
         clear_errors       <= 1'b0;
         capture_off        <= 1'b0;
         count_writes       <= 1'b0;
         timestamps_disable <= 1'b0;
      end else begin
         reg_arm_r     <= reg_arm;
         capture_now_r <= capture_now_q;
         capture_now_q <= arm_wr && acc.wdata[1];  // held while the write lasts

         // an ARM write wins over the capture-enable clear
         if (arm_wr) begin
            if (acc.wdata[0])
               reg_arm <= 1'b1;
         end else if (capture_enable_pulse) begin
            reg_arm <= 1'b0;
         end

         clear_errors <= clr_wr && !clear_errors;  // never two cycles in a row

         if (acc.wr) begin
            case (acc.addr)
               `REG_CAPTURE_OFF:        capture_off        <= acc.wdata[0];
               `REG_COUNT_WRITES:       count_writes       <= acc.wdata[0];
               `REG_TIMESTAMPS_DISABLE: timestamps_disable <= acc.wdata[0];
               default: ;
            endcase
         end
      end
   end

   assign arm_pulse   = reg_arm & ~reg_arm_r;          // rising edge of reg_arm
   assign arm         = reg_arm_r & ~flushing;
   assign capture_now = capture_now_q & ~capture_now_r;

   ////////////////////////////////////////////////////////////
   // multi-byte fields

   byte_field_reg #(
      .field_t   (capture_len_t),
      .RESET_VAL (`CAPTURE_LEN_RESET)
   ) i_capture_len (
      .cwusb_clk  (cwusb_clk),
      .fpga_reset (fpga_reset),
      .wr_en      (acc.wr && (acc.addr == `REG_CAPTURE_LEN)),
      .bytecnt    (acc.bytecnt),
      .wdata      (acc.wdata),
      .value      (capture_len),
      .rd_byte    (len_rd_byte)
   );

   byte_field_reg #(
      .field_t   (max_timestamp_t),
      .RESET_VAL (`MAX_TIMESTAMP_RESET)
   ) i_max_timestamp (
      .cwusb_clk  (cwusb_clk),
      .fpga_reset (fpga_reset),
      .wr_en      (acc.wr && (acc.addr == `REG_MAX_TIMESTAMP)),
      .bytecnt    (acc.bytecnt),
      .wdata      (acc.wdata),
      .value      (max_timestamp),
      .rd_byte    (mts_rd_byte)
   );

   // read-back is zero outside own addresses
   always_comb begin
      rdata = '0;
      if (acc.rd) begin
         case (acc.addr)
            `REG_ARM:                rdata = {7'b0, reg_arm};
            `REG_CAPTURE_OFF:        rdata = {7'b0, capture_off};
            `REG_COUNT_WRITES:       rdata = {7'b0, count_writes};
            `REG_TIMESTAMPS_DISABLE: rdata = {7'b0, timestamps_disable};
            `REG_CAPTURE_LEN:        rdata = len_rd_byte;
            `REG_MAX_TIMESTAMP:      rdata = mts_rd_byte;
            default:                 rdata = '0;
         endcase
      end
   end

endmodule

`default_nettype wire

//--- verilog/byte_field_reg.sv
// byte-addressed multi-byte register field of any packed type
`timescale 1ns/10ps
`default_nettype none

module byte_field_reg
   import main_reg_pkg::*;
#(
   parameter type    field_t   = logic [7:0],
   parameter field_t RESET_VAL = '0
) (
   input  wire           cwusb_clk,
   input  wire           fpga_reset,
   input  wire           wr_en,
   input  wire bytecnt_t bytecnt,
   input  wire byte_t    wdata,
   output field_t        value,
   output byte_t         rd_byte
);

   localparam int W = $bits(field_t);

   logic [W-1:0] field_q;

   // bit i lives in byte i/8, so byte counts past the width match nothing
   always_ff @(posedge cwusb_clk) begin
      if (fpga_reset) begin
         field_q <= RESET_VAL;
      end else if (wr_en) begin
         for (int i = 0; i < W; i++) begin
            if (bytecnt == bytecnt_t'(i / 8))
               field_q[i] <= wdata[i % 8];
         end
      end
   end

   always_comb begin
      rd_byte = '0;   // zero past the top byte
      for (int i = 0; i < W; i++) begin
         if (bytecnt == bytecnt_t'(i / 8))
            rd_byte[i % 8] = field_q[i];
      end
   end

   assign value = field_t'(field_q);

endmodule

`default_nettype wire

//--- verilog/reg_access_if.sv
// decoded register access bundle with driver and receiver modports
`timescale 1ns/10ps
`default_nettype none

interface reg_access_if
   import main_reg_pkg::*;
();

   reg_addr_t addr;        // local address, already inside the window
   bytecnt_t  bytecnt;
   byte_t     wdata;
   logic      wr;          // write qualified by select
   logic      rd;          // read qualified by select
   logic      rd_first;    // first cycle of a selected read

   // bus decoder side
   modport port (
      output addr, bytecnt, wdata, wr, rd, rd_first
   );

   // register blocks
   modport regs (
      input  addr, bytecnt, wdata, wr, rd, rd_first
   );

endinterface

`default_nettype wire

//--- verilog/main_reg_pkg.sv
// shared data types of the main register block
`default_nettype none

package main_reg_pkg;

   ////////////////////////////////////////////////////////////
   // bus side

   typedef logic [7:0] byte_t;          // one bus data byte
   typedef logic [5:0] reg_addr_t;      // address inside the select window
   typedef logic [6:0] bytecnt_t;       // byte index of a multi-byte access

   ////////////////////////////////////////////////////////////
   // FIFO side

   // 16 data bits plus 2 command bits
   typedef logic [17:0] fifo_word_t;

   typedef logic [5:0] fifo_status_t;   // status flags from the FIFO

   ////////////////////////////////////////////////////////////
   // capture control fields

   typedef logic [23:0] capture_len_t;  // samples to capture

   // longest gap between timestamps
   typedef logic [15:0] max_timestamp_t;

endpackage

`default_nettype wire

//--- verilog/main_reg_macros.svh
// register addresses, select window, reset values and FIFO stream marker fields
`ifndef MAIN_REG_MACROS_SVH
`define MAIN_REG_MACROS_SVH

////////////////////////////////////////////////////////////
// select window in the top two bits of the bus address
`define MAIN_REG_SELECT            2'd0

////////////////////////////////////////////////////////////
// local register addresses
`define REG_BUILDTIME              6'd0    // 4 bytes read only
`define REG_FIFO_STAT              6'd1
`define REG_FIFO_RD                6'd2    // 4-byte frames
`define REG_ARM                    6'd3
`define REG_CAPTURE_OFF            6'd4
`define REG_CAPTURE_LEN            6'd5    // 3 bytes
`define REG_COUNT_WRITES           6'd6
`define REG_TIMESTAMPS_DISABLE     6'd7
`define REG_MAX_TIMESTAMP          6'd8    // 2 bytes
`define REG_CLEAR_ERRORS           6'd9

// reset values of the multi-byte fields
`define CAPTURE_LEN_RESET          24'd0
`define MAX_TIMESTAMP_RESET        16'hFFFF

////////////////////////////////////////////////////////////
// streaming empty marker word
`define FIFO_CMD_START             0
`define FIFO_CMD_LEN               2
`define FIFO_CMD_STRM              2'd3
`define FIFO_DATA_START            2
`define FIFO_DATA_LEN              8
`define FIFO_STRM_EMPTY            8'd0

`endif
